// File: common/bpu_pkg.sv
// bpu_pkg: update path sizes, branch kind encoding, resolve entry and update record types
`default_nettype none

package bpu_pkg;

    localparam int queue_depth = 6;
    localparam int pc_w        = 30;  // word address
    localparam int bh_w        = 14;
    localparam int pdch_w      = 8;
    localparam int pht_entries = 1 << pdch_w;

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = $clog2(queue_depth + 1);

    typedef logic [ptr_w-1:0] qptr_t;
    typedef logic [cnt_w-1:0] qcnt_t;
    typedef logic [pc_w-1:0]  pc_t;

    localparam qptr_t      last_slot = qptr_t'(queue_depth - 1);
    localparam logic [1:0] ctr_init  = 2'b01;  // weakly not taken

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        jump          = 3'd2,
        call          = 3'd3,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        other_jump    = 3'd6
    } branch_kind_t;

    // 124 bits, msb first
    typedef struct packed {
        logic [pdch_w-1:0] pdch;
        logic              flush_pre;   // second instruction of packet flushed
        logic [bh_w-1:0]   bh_pdc;
        logic              pack_size;   // packet held two instructions
        logic [1:0]        choice_pdc;
        pc_t               pc_ex;
        pc_t               npc_ex;
        branch_kind_t      kind_ex;
        logic              taken_ex;
        pc_t               npc_pdc;
        branch_kind_t      kind_pdc;
        logic              taken_pdc;
    } resolve_entry_t;

    typedef struct packed {
        logic [pdch_w-1:0] pdch;
        logic [bh_w-1:0]   bh_pdc;
        logic [1:0]        choice_pdc;
        pc_t               pc_ex;
        pc_t               npc_ex;
        branch_kind_t      kind_ex;
        logic              taken_ex;
        pc_t               npc_pdc;
        branch_kind_t      kind_pdc;
        logic              taken_pdc;
    } update_rec_t;

endpackage

`default_nettype wire

// File: update_buffer/resolve_queue.sv
// resolve_queue: circular queue of resolved branch entries, two pushes and single or pair pop
`default_nettype none

module resolve_queue (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic [1:0]              lane_valid,
    input  wire bpu_pkg::resolve_entry_t lane0,
    input  wire bpu_pkg::resolve_entry_t lane1,
    input  wire logic                    stall,
    output logic                         pop_valid,
    output logic                         pop_pair,
    output bpu_pkg::resolve_entry_t      head,
    output bpu_pkg::resolve_entry_t      next
);

    bpu_pkg::resolve_entry_t mem [bpu_pkg::queue_depth];

    bpu_pkg::qptr_t rd_ptr;
    bpu_pkg::qptr_t wr_ptr;
    bpu_pkg::qcnt_t count;

    bpu_pkg::qptr_t rd_ptr_1;
    bpu_pkg::qptr_t wr_ptr_1;
    logic [1:0]     push_n;
    logic [1:0]     pop_n;
    logic           head_single;

    function automatic bpu_pkg::qptr_t ptr_inc(input bpu_pkg::qptr_t ptr);
        return (ptr == bpu_pkg::last_slot) ? '0 : ptr + bpu_pkg::qptr_t'(1);
    endfunction

    assign rd_ptr_1 = ptr_inc(rd_ptr);
    assign wr_ptr_1 = ptr_inc(wr_ptr);

    assign head = mem[rd_ptr];
    assign next = mem[rd_ptr_1];

    // second instruction flushed means the packet resolves alone
    assign head_single = !head.pack_size || head.flush_pre;

    // pair head waits here until its partner is in
    assign pop_pair  = (count >= bpu_pkg::qcnt_t'(2)) && !head_single;
    assign pop_valid = ((count != '0) && head_single) || pop_pair;

    assign push_n = stall ? 2'd0 : {1'b0, lane_valid[0]} + {1'b0, lane_valid[1]};
    assign pop_n  = {pop_pair, pop_valid & ~pop_pair};

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (lane_valid[0]) begin
                mem[wr_ptr] <= lane0;
            end
            if (lane_valid[1]) begin
                mem[lane_valid[0] ? wr_ptr_1 : wr_ptr] <= lane1;  // lane 0 goes first
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            case (pop_n)
                2'd1:    rd_ptr <= rd_ptr_1;
                2'd2:    rd_ptr <= ptr_inc(rd_ptr_1);
                default: rd_ptr <= rd_ptr;
            endcase

            case (push_n)
                2'd1:    wr_ptr <= wr_ptr_1;
                2'd2:    wr_ptr <= ptr_inc(wr_ptr_1);
                default: wr_ptr <= wr_ptr;
            endcase

            count <= count + bpu_pkg::qcnt_t'(push_n) - bpu_pkg::qcnt_t'(pop_n);
        end
    end

endmodule

`default_nettype wire

// File: update_buffer/update_merge.sv
// update_merge: folds a popped single or pair into one registered update record and return pc
`default_nettype none

module update_merge (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    pop_valid,
    input  wire logic                    pop_pair,
    input  wire bpu_pkg::resolve_entry_t head,
    input  wire bpu_pkg::resolve_entry_t next,
    output logic                         update_en,
    output bpu_pkg::update_rec_t         update_rec,
    output bpu_pkg::pc_t                 ret_pc
);

    bpu_pkg::update_rec_t rec_nxt;
    bpu_pkg::pc_t         ret_nxt;

    function automatic bpu_pkg::update_rec_t to_rec(input bpu_pkg::resolve_entry_t e);
        bpu_pkg::update_rec_t r;
        r.pdch       = e.pdch;
        r.bh_pdc     = e.bh_pdc;
        r.choice_pdc = e.choice_pdc;
        r.pc_ex      = e.pc_ex;
        r.npc_ex     = e.npc_ex;
        r.kind_ex    = e.kind_ex;
        r.taken_ex   = e.taken_ex;
        r.npc_pdc    = e.npc_pdc;
        r.kind_pdc   = e.kind_pdc;
        r.taken_pdc  = e.taken_pdc;
        return r;
    endfunction

    // highest kind present in the pair, plain jump counts as not_jump
    function automatic bpu_pkg::branch_kind_t kind_merge(input bpu_pkg::branch_kind_t a,
                                                         input bpu_pkg::branch_kind_t b);
        if (a == bpu_pkg::direct_jump || b == bpu_pkg::direct_jump) begin
            return bpu_pkg::direct_jump;
        end else if (a == bpu_pkg::call || b == bpu_pkg::call) begin
            return bpu_pkg::call;
        end else if (a == bpu_pkg::ret || b == bpu_pkg::ret) begin
            return bpu_pkg::ret;
        end else if (a == bpu_pkg::indirect_jump || b == bpu_pkg::indirect_jump) begin
            return bpu_pkg::indirect_jump;
        end else if (a == bpu_pkg::other_jump || b == bpu_pkg::other_jump) begin
            return bpu_pkg::other_jump;
        end
        return bpu_pkg::not_jump;
    endfunction

    always_comb begin
        rec_nxt = to_rec(head);  // prediction side and pc_ex always from the first
        if (pop_pair) begin
            rec_nxt.taken_ex = head.taken_ex | next.taken_ex;
            rec_nxt.kind_ex  = kind_merge(head.kind_ex, next.kind_ex);
            rec_nxt.npc_ex   = head.taken_ex ? head.npc_ex : next.npc_ex;
        end
    end

    // call in the second slot returns past the second instruction
    always_comb begin
        if (pop_pair && head.kind_ex != bpu_pkg::call && next.kind_ex == bpu_pkg::call) begin
            ret_nxt = next.pc_ex + bpu_pkg::pc_t'(1);
        end else begin
            ret_nxt = head.pc_ex + bpu_pkg::pc_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            update_en  <= 1'b0;
            update_rec <= '0;
            ret_pc     <= '0;
        end else begin
            update_en <= pop_valid;
            if (pop_valid) begin
                update_rec <= rec_nxt;
                ret_pc     <= ret_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pattern_table.sv
// pattern_table: two-bit saturating pattern counters trained by update records, lookup port
`default_nettype none

module pattern_table (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic                      update_en,
    input  wire bpu_pkg::update_rec_t      update_rec,
    input  wire logic [bpu_pkg::pdch_w-1:0] lookup_index,
    output logic                           lookup_taken
);

    logic [1:0] ctr [bpu_pkg::pht_entries];

    logic [1:0] ctr_cur;
    logic [1:0] ctr_nxt;

    assign ctr_cur = ctr[update_rec.pdch];

    always_comb begin
        ctr_nxt = ctr_cur;
        if (update_rec.taken_ex) begin
            if (ctr_cur != 2'b11) begin
                ctr_nxt = ctr_cur + 2'b01;
            end
        end else if (ctr_cur != 2'b00) begin
            ctr_nxt = ctr_cur - 2'b01;
        end
    end

    // whole table back to weakly not taken in one reset clock
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bpu_pkg::pht_entries; i++) begin
                ctr[i] <= bpu_pkg::ctr_init;
            end
        end else if (update_en) begin
            ctr[update_rec.pdch] <= ctr_nxt;
        end
    end

    assign lookup_taken = ctr[lookup_index][1];  // msb is the direction

endmodule

`default_nettype wire

// File: rtl/bpu_update_top.sv
// bpu_update_top: resolve queue, update merge and pattern table of the predictor update path
`default_nettype none

module bpu_update_top (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic [1:0]                 lane_valid,
    input  wire bpu_pkg::resolve_entry_t    lane0,
    input  wire bpu_pkg::resolve_entry_t    lane1,
    input  wire logic                       stall,
    input  wire logic [bpu_pkg::pdch_w-1:0] lookup_index,
    output logic                            update_en,
    output bpu_pkg::update_rec_t            update_rec,
    output bpu_pkg::pc_t                    ret_pc,
    output logic                            lookup_taken
);

    logic                    pop_valid;
    logic                    pop_pair;
    bpu_pkg::resolve_entry_t head;
    bpu_pkg::resolve_entry_t next;

    resolve_queue resolve_queue_inst (
        .clk        (clk),
        .rstn       (rstn),
        .lane_valid (lane_valid),
        .lane0      (lane0),
        .lane1      (lane1),
        .stall      (stall),
        .pop_valid  (pop_valid),
        .pop_pair   (pop_pair),
        .head       (head),
        .next       (next)
    );

    update_merge update_merge_inst (
        .clk        (clk),
        .rstn       (rstn),
        .pop_valid  (pop_valid),
        .pop_pair   (pop_pair),
        .head       (head),
        .next       (next),
        .update_en  (update_en),
        .update_rec (update_rec),
        .ret_pc     (ret_pc)
    );

    pattern_table pattern_table_inst (
        .clk          (clk),
        .rstn         (rstn),
        .update_en    (update_en),
        .update_rec   (update_rec),
        .lookup_index (lookup_index),
        .lookup_taken (lookup_taken)
    );

endmodule

`default_nettype wire

// File: testbench/bpu_update_checker.sv
// bpu_update_checker: compares update records and final pattern counters against testdata
`default_nettype none

module bpu_update_checker (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 update_en,
    input  wire bpu_pkg::update_rec_t update_rec,
    input  wire bpu_pkg::pc_t         ret_pc,
    input  wire logic                 lookup_taken,
    input  wire logic                 ctr_check,
    input  int                        ctr_slot,
    output int                        errors,
    output int                        checks,
    output int                        tests_done,
    output int                        recs_left
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] td [0:1023];
    logic [1:0]  model [bpu_pkg::pht_entries];

    int n_stim;
    int n_exp;
    int n_ctr;
    int exp_base;
    int ctr_base;
    int rec_ptr;
    int test_errors;

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            $display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test(input int test_no);
        if (test_errors == 0) begin
            $display("test %0d passed", test_no);
        end else begin
            $display("test %0d failed, %0d mismatches", test_no, test_errors);
        end
        tests_done++;
        test_errors = 0;
    endtask

    initial begin
        int b;
        $readmemh("testbench/bpu_update_testdata.hex", td);
        n_stim      = int'(td[0]);
        n_exp       = int'(td[1]);
        n_ctr       = int'(td[2]);
        exp_base    = 3 + 27 * n_stim;
        ctr_base    = exp_base + 12 * n_exp;
        errors      = 0;
        checks      = 0;
        tests_done  = 0;
        recs_left   = n_exp;
        rec_ptr     = 0;
        test_errors = 0;
        for (int i = 0; i < bpu_pkg::pht_entries; i++) begin
            model[i] = 2'b01;
        end
        // counters trained by expected records in order
        for (int r = 0; r < n_exp; r++) begin
            b = exp_base + 12 * r;
            if (td[b+7][0]) begin
                if (model[td[b+6][7:0]] != 2'b11) model[td[b+6][7:0]]++;
            end else if (model[td[b+6][7:0]] != 2'b00) begin
                model[td[b+6][7:0]]--;
            end
        end
    end

    always @(posedge clk) begin
        int b;
        if (rstn && update_en) begin
            if (rec_ptr >= n_exp) begin
                $display("update record seen after all expected records were used");
                errors++;
            end else begin
                b = exp_base + 12 * rec_ptr;
                compare_field("taken_pdc", td[b+1], 32'(update_rec.taken_pdc));
                compare_field("kind_pdc", td[b+2], 32'(update_rec.kind_pdc));
                compare_field("npc_pdc", td[b+3], 32'(update_rec.npc_pdc));
                compare_field("choice_pdc", td[b+4], 32'(update_rec.choice_pdc));
                compare_field("bh_pdc", td[b+5], 32'(update_rec.bh_pdc));
                compare_field("pdch", td[b+6], 32'(update_rec.pdch));
                compare_field("taken_ex", td[b+7], 32'(update_rec.taken_ex));
                compare_field("kind_ex", td[b+8], 32'(update_rec.kind_ex));
                compare_field("npc_ex", td[b+9], 32'(update_rec.npc_ex));
                compare_field("pc_ex", td[b+10], 32'(update_rec.pc_ex));
                compare_field("ret_pc", td[b+11], 32'(ret_pc));
                rec_ptr++;
                recs_left--;
                if (rec_ptr == n_exp || td[b+12] != td[b]) begin
                    close_test(int'(td[b]));  // last record of this test
                end
            end
        end
    end

    always @(posedge clk) begin
        logic [7:0] idx;
        logic [1:0] exp_ctr;
        if (ctr_check) begin
            idx     = td[ctr_base + 2 * ctr_slot][7:0];
            exp_ctr = td[ctr_base + 2 * ctr_slot + 1][1:0];
            if (model[idx] != exp_ctr) begin
                $display("testdata counter at index %h disagrees with the record model", idx);
                errors++;
                test_errors++;
            end
            compare_field("lookup_taken", 32'(exp_ctr[1]), 32'(lookup_taken));
            if (ctr_slot == n_ctr - 1) begin
                close_test(6);  // counter readback
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/bpu_update_assert.sv
// bpu_update_assert: queue occupancy, pair pop and reset checks bound into the update path
`default_nettype none

module bpu_update_assert (
    input wire logic           clk,
    input wire logic           rstn,
    input wire logic [1:0]     lane_valid,
    input wire logic           stall,
    input wire bpu_pkg::qcnt_t count,
    input wire logic           pop_valid,
    input wire logic           pop_pair,
    input wire logic           update_en
);

    timeunit 1ns;
    timeprecision 100ps;

    int occupancy;  // entries pushed and not yet retired, seen from the ports
    int pushed;
    int retired;

    always_comb begin
        pushed  = stall ? 0 : int'(lane_valid[0]) + int'(lane_valid[1]);
        retired = pop_pair ? 2 : (pop_valid ? 1 : 0);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + pushed - retired;
        end
    end

    // producer must never overrun the queue
    count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= bpu_pkg::qcnt_t'(bpu_pkg::queue_depth))
        else $error("queue count above depth");

    pair_needs_two: assert property (@(posedge clk) disable iff (!rstn)
        pop_pair |-> occupancy >= 2)
        else $error("pair pop with fewer than two entries");

    reset_quiet: assert property (@(posedge clk) !rstn |=> !update_en)
        else $error("update_en high during reset");

endmodule

bind bpu_update_top bpu_update_assert bpu_update_assert_inst (
    .clk        (clk),
    .rstn       (rstn),
    .lane_valid (lane_valid),
    .stall      (stall),
    .count      (resolve_queue_inst.count),
    .pop_valid  (pop_valid),
    .pop_pair   (pop_pair),
    .update_en  (update_en)
);

`default_nettype wire

// File: testbench/tb_bpu_update.sv
// tb_bpu_update: clock, reset, testdata stimulus, timeout and closing summary
`default_nettype none

module tb_bpu_update;

    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk;
    logic                    rstn;
    logic [1:0]              lane_valid;
    bpu_pkg::resolve_entry_t lane0;
    bpu_pkg::resolve_entry_t lane1;
    logic                    stall;
    logic [bpu_pkg::pdch_w-1:0] lookup_index;
    logic                    update_en;
    bpu_pkg::update_rec_t    update_rec;
    bpu_pkg::pc_t            ret_pc;
    logic                    lookup_taken;

    logic ctr_check;
    int   ctr_slot;
    int   errors;
    int   checks;
    int   tests_done;
    int   recs_left;

    logic [31:0] td [0:1023];
    int n_stim;
    int n_exp;
    int n_ctr;
    int ctr_base;
    int cycle_limit;
    int cycles;

    bpu_update_top bpu_update_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .lane_valid   (lane_valid),
        .lane0        (lane0),
        .lane1        (lane1),
        .stall        (stall),
        .lookup_index (lookup_index),
        .update_en    (update_en),
        .update_rec   (update_rec),
        .ret_pc       (ret_pc),
        .lookup_taken (lookup_taken)
    );

    bpu_update_checker bpu_update_checker_inst (
        .clk          (clk),
        .rstn         (rstn),
        .update_en    (update_en),
        .update_rec   (update_rec),
        .ret_pc       (ret_pc),
        .lookup_taken (lookup_taken),
        .ctr_check    (ctr_check),
        .ctr_slot     (ctr_slot),
        .errors       (errors),
        .checks       (checks),
        .tests_done   (tests_done),
        .recs_left    (recs_left)
    );

    // twelve words per lane, same order as the testdata columns
    function automatic bpu_pkg::resolve_entry_t build_entry(input int b);
        bpu_pkg::resolve_entry_t e;
        e.taken_pdc  = td[b][0];
        e.kind_pdc   = bpu_pkg::branch_kind_t'(td[b+1][2:0]);
        e.npc_pdc    = td[b+2][bpu_pkg::pc_w-1:0];
        e.choice_pdc = td[b+3][1:0];
        e.bh_pdc     = td[b+4][bpu_pkg::bh_w-1:0];
        e.pdch       = td[b+5][bpu_pkg::pdch_w-1:0];
        e.taken_ex   = td[b+6][0];
        e.kind_ex    = bpu_pkg::branch_kind_t'(td[b+7][2:0]);
        e.npc_ex     = td[b+8][bpu_pkg::pc_w-1:0];
        e.pc_ex      = td[b+9][bpu_pkg::pc_w-1:0];
        e.pack_size  = td[b+10][0];
        e.flush_pre  = td[b+11][0];
        return e;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rstn) begin
            cycles <= cycles + 1;
            if (cycles > cycle_limit) begin
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    initial begin
        int b;
        $readmemh("testbench/bpu_update_testdata.hex", td);
        n_stim      = int'(td[0]);
        n_exp       = int'(td[1]);
        n_ctr       = int'(td[2]);
        ctr_base    = 3 + 27 * n_stim + 12 * n_exp;
        cycle_limit = n_stim + bpu_pkg::queue_depth + 20;
        cycles       = 0;
        rstn         = 1'b0;
        lane_valid   = 2'b00;
        lane0        = '0;
        lane1        = '0;
        stall        = 1'b0;
        lookup_index = '0;
        ctr_check    = 1'b0;
        ctr_slot     = 0;

        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < n_stim; i++) begin
            @(posedge clk);
            b = 3 + 27 * i;
            lane_valid <= td[b+1][1:0];
            stall      <= td[b+2][0];
            lane0      <= build_entry(b + 3);
            lane1      <= build_entry(b + 15);
        end
        @(posedge clk);
        lane_valid <= 2'b00;
        stall      <= 1'b0;

        while (recs_left != 0) @(negedge clk);  // timeout catches missing records
        repeat (2) @(posedge clk);

        for (int s = 0; s < n_ctr; s++) begin
            @(posedge clk);
            lookup_index <= td[ctr_base + 2 * s][bpu_pkg::pdch_w-1:0];
            ctr_slot     <= s;
            ctr_check    <= 1'b1;
        end
        @(posedge clk);
        ctr_check <= 1'b0;
        @(negedge clk);

        $display("tests %0d, checks %0d, errors %0d, records missing %0d",
                 tests_done, checks, errors, recs_left);
        if (errors == 0 && recs_left == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/bpu_update_testdata.hex
// header: stimulus lines, expected records, counter checks
// stim: test lane_valid stall, then per lane: tp kp npc ch bh pdch te ke npc_ex pc_ex ps fp
// exp: test tp kp npc ch bh pdch te ke npc_ex pc_ex ret_pc ; ctr: index counter
14 c 9
1 1 0 1 1 40 1 a 10 1 1 40 20 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 3 0 0 0 0 0 0 10 1 0 51 50 0 0 0 0 0 2 3 10 1 0 61 60 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 3 0 1 3 100 3 1f 20 1 0 80 70 1 0 0 0 0 0 0 0 0 3 90 71 0 0
2 3 0 0 0 0 0 2 20 0 6 0 110 1 0 0 0 0 0 0 0 1 1 130 111 0 0
2 3 0 0 0 0 0 0 21 0 4 0 140 1 0 0 0 0 0 0 0 0 5 150 141 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 30 1 2 200 1a0 1 1 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 31 0 0 0 1b0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 0 1 3 300 1b1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 3 0 0 0 0 0 0 40 1 3 400 3f0 1 0 0 0 0 0 0 0 1 3 500 3f1 0 0
4 1 0 0 0 0 0 0 40 0 3 410 400 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 3 1 0 0 0 0 0 50 1 1 700 6f0 0 0 0 0 0 0 0 50 1 1 710 6f1 0 0
5 3 0 0 0 0 0 0 50 0 0 601 600 0 0 0 0 0 0 0 50 0 0 611 610 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 40 1 a 10 1 1 40 20 21
1 0 0 0 0 0 10 1 0 51 50 51
1 0 0 0 2 3 10 1 0 61 60 61
2 1 3 100 3 1f 20 1 3 80 70 72
2 0 0 0 0 2 20 1 1 130 110 111
2 0 0 0 0 0 21 0 4 150 140 141
3 0 0 0 0 0 30 1 2 200 1a0 1a1
3 0 0 0 0 0 31 1 3 300 1b0 1b2
4 0 0 0 0 0 40 1 3 400 3f0 3f1
4 0 0 0 0 0 40 0 3 410 400 401
5 0 0 0 0 0 50 0 0 601 600 601
5 0 0 0 0 0 50 0 0 611 610 611
10 3
11 1
20 3
21 0
30 2
31 2
40 1
50 0
ff 1

// File: bpu_update.f
common/bpu_pkg.sv
update_buffer/resolve_queue.sv
update_buffer/update_merge.sv
rtl/pattern_table.sv
rtl/bpu_update_top.sv
testbench/bpu_update_checker.sv
testbench/bpu_update_assert.sv
testbench/tb_bpu_update.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_bpu_update
FILELIST  = bpu_update.f
OBJ_DIR   = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
